// File: source/id_pkg.sv
// Decode stage package
// Widths, opcode and operator encodings, selectors and the structs shared by the stage

package id_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes kept in this core
  typedef enum logic [6:0] {
    OPC_LOAD    = 7'h03,
    OPC_CUSTOM0 = 7'h0b,
    OPC_OP_IMM  = 7'h13,
    OPC_STORE   = 7'h23,
    OPC_OP      = 7'h33,
    OPC_LUI     = 7'h37,
    OPC_BRANCH  = 7'h63,
    OPC_JAL     = 7'h6f
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Comparisons for branches
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_MUL
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // INCR_PC is the fixed step of 4 to the next instruction
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    logic       rf_we;
    logic       rf_ren_a;
    logic       rf_ren_b;
    logic       lsu_req;
    logic       lsu_we;
    lsu_size_e  lsu_size;
    logic       lsu_sign_ext;
    logic       branch;
    logic       jump;
    logic       mac;
    logic       illegal;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

  typedef struct packed {
    logic            req;
    logic            we;
    lsu_size_e       size;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_state_e;

endpackage

// File: source/id_decoder.sv
// Instruction decoder
// Turns an RV32I word into control bits, register indices and the selected immediate

`timescale 1ns/1ps

module id_decoder #(
  parameter bit MacEn = 1'b1
) (
  input  logic [id_pkg::XLEN-1:0]       instr_i,
  input  logic                          instr_valid_i,
  output id_pkg::dec_ctrl_t             ctrl_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rs2_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [id_pkg::XLEN-1:0]       imm_o
);

  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              illegal;
  id_pkg::dec_ctrl_t ctrl_d;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    ctrl_d  = '0;
    illegal = 1'b0;
    case (id_pkg::opcode_e'(instr_i[6:0]))
      id_pkg::OPC_OP: begin
        ctrl_d.rf_we    = 1'b1;
        ctrl_d.rf_ren_a = 1'b1;
        ctrl_d.rf_ren_b = 1'b1;
        if (funct7 == 7'h00) begin
          case (funct3)
            3'd0:    ctrl_d.alu_op = id_pkg::ALU_ADD;
            3'd1:    ctrl_d.alu_op = id_pkg::ALU_SLL;
            3'd2:    ctrl_d.alu_op = id_pkg::ALU_SLT;
            3'd3:    ctrl_d.alu_op = id_pkg::ALU_SLTU;
            3'd4:    ctrl_d.alu_op = id_pkg::ALU_XOR;
            3'd5:    ctrl_d.alu_op = id_pkg::ALU_SRL;
            3'd6:    ctrl_d.alu_op = id_pkg::ALU_OR;
            default: ctrl_d.alu_op = id_pkg::ALU_AND;
          endcase
        end else if (funct7 == 7'h20 && funct3 == 3'd0) begin
          ctrl_d.alu_op = id_pkg::ALU_SUB;
        end else if (funct7 == 7'h20 && funct3 == 3'd5) begin
          ctrl_d.alu_op = id_pkg::ALU_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      id_pkg::OPC_OP_IMM: begin
        ctrl_d.rf_we    = 1'b1;
        ctrl_d.rf_ren_a = 1'b1;
        ctrl_d.op_b_sel = id_pkg::OP_B_IMM;
        case (funct3)
          3'd0: ctrl_d.alu_op = id_pkg::ALU_ADD;
          3'd2: ctrl_d.alu_op = id_pkg::ALU_SLT;
          3'd3: ctrl_d.alu_op = id_pkg::ALU_SLTU;
          3'd4: ctrl_d.alu_op = id_pkg::ALU_XOR;
          3'd6: ctrl_d.alu_op = id_pkg::ALU_OR;
          3'd7: ctrl_d.alu_op = id_pkg::ALU_AND;
          3'd1: begin
            ctrl_d.alu_op = id_pkg::ALU_SLL;
            illegal       = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            ctrl_d.alu_op = (funct7 == 7'h20) ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            illegal       = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      id_pkg::OPC_LUI: begin
        ctrl_d.rf_we     = 1'b1;
        ctrl_d.op_a_sel  = id_pkg::OP_A_ZERO;
        ctrl_d.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_d.imm_b_sel = id_pkg::IMM_B_U;
      end
      id_pkg::OPC_LOAD: begin
        ctrl_d.rf_we        = 1'b1;
        ctrl_d.rf_ren_a     = 1'b1;
        ctrl_d.op_b_sel     = id_pkg::OP_B_IMM;
        ctrl_d.lsu_req      = 1'b1;
        ctrl_d.lsu_size     = id_pkg::lsu_size_e'(funct3[1:0]);
        ctrl_d.lsu_sign_ext = ~funct3[2];
        // Valid sizes are 0, 1, 2, 4 and 5
        illegal = (funct3[1:0] == 2'd3) || (funct3 == 3'd6);
      end
      id_pkg::OPC_STORE: begin
        ctrl_d.rf_ren_a  = 1'b1;
        ctrl_d.rf_ren_b  = 1'b1;
        ctrl_d.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_d.imm_b_sel = id_pkg::IMM_B_S;
        ctrl_d.lsu_req   = 1'b1;
        ctrl_d.lsu_we    = 1'b1;
        ctrl_d.lsu_size  = id_pkg::lsu_size_e'(funct3[1:0]);
        illegal          = (funct3 > 3'd2);
      end
      id_pkg::OPC_BRANCH: begin
        // Compare on registers first, target uses the B immediate later
        ctrl_d.rf_ren_a  = 1'b1;
        ctrl_d.rf_ren_b  = 1'b1;
        ctrl_d.imm_b_sel = id_pkg::IMM_B_B;
        ctrl_d.branch    = 1'b1;
        case (funct3)
          3'd0:    ctrl_d.alu_op = id_pkg::ALU_EQ;
          3'd1:    ctrl_d.alu_op = id_pkg::ALU_NE;
          3'd4:    ctrl_d.alu_op = id_pkg::ALU_LT;
          3'd5:    ctrl_d.alu_op = id_pkg::ALU_GE;
          3'd6:    ctrl_d.alu_op = id_pkg::ALU_LTU;
          3'd7:    ctrl_d.alu_op = id_pkg::ALU_GEU;
          default: illegal       = 1'b1;
        endcase
      end
      id_pkg::OPC_JAL: begin
        ctrl_d.rf_we     = 1'b1;
        ctrl_d.op_a_sel  = id_pkg::OP_A_CURRPC;
        ctrl_d.op_b_sel  = id_pkg::OP_B_IMM;
        ctrl_d.imm_b_sel = id_pkg::IMM_B_J;
        ctrl_d.jump      = 1'b1;
      end
      id_pkg::OPC_CUSTOM0: begin
        // rd + rs1 * rs2, port A rereads rd in the second cycle
        ctrl_d.rf_we    = 1'b1;
        ctrl_d.rf_ren_a = 1'b1;
        ctrl_d.rf_ren_b = 1'b1;
        ctrl_d.alu_op   = id_pkg::ALU_MUL;
        ctrl_d.mac      = 1'b1;
        illegal         = !MacEn || (funct3 != 3'd0) || (funct7 != 7'h00);
      end
      default: illegal = 1'b1;
    endcase

    // No write to x0
    if (rd_o == '0) begin
      ctrl_d.rf_we = 1'b0;
    end
    if (illegal) begin
      ctrl_d         = '0;
      ctrl_d.illegal = 1'b1;
    end
  end

  assign ctrl_o = instr_valid_i ? ctrl_d : '0;

  ////////////////////////////////////////
  // Immediate select
  ////////////////////////////////////////

  always_comb begin
    case (ctrl_o.imm_b_sel)
      id_pkg::IMM_B_S: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      id_pkg::IMM_B_B: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                instr_i[30:25], instr_i[11:8], 1'b0};
      id_pkg::IMM_B_U: imm_o = {instr_i[31:12], 12'b0};
      id_pkg::IMM_B_J: imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                instr_i[20], instr_i[30:21], 1'b0};
      id_pkg::IMM_B_INCR_PC: imm_o = id_pkg::XLEN'(4);
      default: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // Only one multi-cycle class per instruction
  always_comb begin
    if (instr_valid_i) begin
      assert ($onehot0({ctrl_o.lsu_req, ctrl_o.branch, ctrl_o.jump, ctrl_o.mac}))
        else $error("decoder raised more than one multi-cycle flag");
    end
  end

endmodule

// File: source/id_operand_mux.sv
// ALU operand selection
// Picks operands A and B, with the branch target and jump link pair after the first cycle

`timescale 1ns/1ps

module id_operand_mux (
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  logic                    first_cycle_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  logic [id_pkg::XLEN-1:0] rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rdata_b_i,
  input  logic [id_pkg::XLEN-1:0] imm_i,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o
);

  always_comb begin
    case (ctrl_i.op_a_sel)
      id_pkg::OP_A_CURRPC: operand_a_o = pc_i;
      id_pkg::OP_A_ZERO:   operand_a_o = '0;
      default:             operand_a_o = rdata_a_i;
    endcase
    operand_b_o = (ctrl_i.op_b_sel == id_pkg::OP_B_IMM) ? imm_i : rdata_b_i;

    // Second cycle of a branch is the target, of a jump the link value
    if ((ctrl_i.branch || ctrl_i.jump) && !first_cycle_i) begin
      operand_a_o = pc_i;
      operand_b_o = ctrl_i.branch ? imm_i : id_pkg::XLEN'(4);
    end
  end

endmodule

// File: source/id_mac_sequencer.sv
// MAC sequencer
// Holds the product of the multiply cycle and turns the next cycle into rd + product

`timescale 1ns/1ps

module id_mac_sequencer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          mac_i,
  input  logic                          first_cycle_i,
  input  id_pkg::alu_op_e               alu_op_i,
  input  logic [id_pkg::XLEN-1:0]       operand_b_i,
  input  logic [id_pkg::XLEN-1:0]       result_ex_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rd_i,
  output id_pkg::alu_op_e               alu_op_o,
  output logic [id_pkg::XLEN-1:0]       operand_b_o,
  output logic [id_pkg::REG_ADDR_W-1:0] raddr_a_o
);

  logic                    mul_cycle;
  logic                    acc_cycle;
  logic [id_pkg::XLEN-1:0] product_q;

  assign mul_cycle = mac_i & first_cycle_i;
  assign acc_cycle = mac_i & ~first_cycle_i;

  // Product from EX, taken at the end of the multiply cycle
  always_ff @(posedge clk_i) begin
    if (mul_cycle) begin
      product_q <= result_ex_i;
    end
  end

  // Accumulate: port A reads rd, B is the held product
  assign alu_op_o    = acc_cycle ? id_pkg::ALU_ADD : alu_op_i;
  assign operand_b_o = acc_cycle ? product_q : operand_b_i;
  assign raddr_a_o   = acc_cycle ? rd_i : rs1_i;

  // Accumulate comes right after the multiply of the same instruction
  acc_after_mul_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_cycle |-> $past(mul_cycle) && ($past(rd_i) == rd_i));

endmodule

// File: source/id_fsm.sv
// ID-EX state machine
// Stall causes, one-shot pc set, write-back gating, LSU request and instruction done

`timescale 1ns/1ps

module id_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          instr_valid_i,
  input  id_pkg::dec_ctrl_t             ctrl_i,
  input  logic                          branch_decision_i,
  input  logic                          lsu_resp_valid_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [id_pkg::XLEN-1:0]       lsu_wdata_i,
  input  logic [id_pkg::XLEN-1:0]       result_ex_i,
  output logic                          first_cycle_o,
  output logic                          pc_set_o,
  output logic                          instr_done_o,
  output logic                          illegal_insn_o,
  output id_pkg::rf_wr_t                rf_wr_o,
  output id_pkg::lsu_req_t              lsu_req_o
);

  id_pkg::id_state_e state_q, state_d;
  logic stall_mem, stall_branch, stall_jump, stall_mac, stall_id;
  logic branch_set_d, branch_set_q, jump_set;
  logic set_done_q;

  assign first_cycle_o = instr_valid_i & (state_q == id_pkg::FIRST_CYCLE);

  // Loads and stores stall in cycle 1 and then until the response
  assign stall_mem = instr_valid_i & ctrl_i.lsu_req & (first_cycle_o | ~lsu_resp_valid_i);

  always_comb begin
    state_d      = state_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    stall_mac    = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;
    if (state_q == id_pkg::FIRST_CYCLE) begin
      if (ctrl_i.lsu_req) begin
        state_d = id_pkg::MULTI_CYCLE;
      end else if (ctrl_i.branch && branch_decision_i) begin
        // Target is formed in the next cycle
        state_d      = id_pkg::MULTI_CYCLE;
        stall_branch = 1'b1;
        branch_set_d = 1'b1;
      end else if (ctrl_i.jump) begin
        state_d    = id_pkg::MULTI_CYCLE;
        stall_jump = 1'b1;
        jump_set   = 1'b1;
      end else if (ctrl_i.mac) begin
        state_d   = id_pkg::MULTI_CYCLE;
        stall_mac = 1'b1;
      end
    end else if (!ctrl_i.lsu_req || lsu_resp_valid_i) begin
      // Branch, jump and MAC end here, memory waits for its response
      state_d = id_pkg::FIRST_CYCLE;
    end
  end

  assign stall_id     = stall_mem | stall_branch | stall_jump | stall_mac;
  assign instr_done_o = instr_valid_i & ~stall_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= id_pkg::FIRST_CYCLE;
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        state_q <= state_d;
      end
      branch_set_q <= branch_set_d;
      // Remembers a pc set until the instruction retires
      set_done_q   <= (pc_set_o | set_done_q) & ~instr_done_o;
    end
  end

  assign pc_set_o       = (branch_set_q | jump_set) & ~set_done_q;
  assign illegal_insn_o = instr_valid_i & ctrl_i.illegal;

  // Write back only in the done cycle
  assign rf_wr_o.we    = ctrl_i.rf_we & instr_done_o;
  assign rf_wr_o.waddr = rd_i;
  assign rf_wr_o.wdata = result_ex_i;

  assign lsu_req_o.req      = ctrl_i.lsu_req & first_cycle_o;
  assign lsu_req_o.we       = ctrl_i.lsu_we;
  assign lsu_req_o.size     = ctrl_i.lsu_size;
  assign lsu_req_o.sign_ext = ctrl_i.lsu_sign_ext;
  assign lsu_req_o.wdata    = lsu_wdata_i;

  // Entering MULTI_CYCLE needs a stall in the cycle before
  multi_needs_stall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == id_pkg::MULTI_CYCLE) && ($past(state_q) == id_pkg::FIRST_CYCLE)
    |-> $past(stall_id));

endmodule

// File: source/id_stage.sv
// Instruction decode stage of a small RV32I core
// Decoder, operand mux, MAC sequencer and ID-EX FSM, one instruction in flight

`timescale 1ns/1ps

module id_stage #(
  parameter bit MacEn = 1'b1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          instr_valid_i,
  input  logic [id_pkg::XLEN-1:0]       instr_i,
  input  logic [id_pkg::XLEN-1:0]       pc_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_b_i,
  input  logic [id_pkg::XLEN-1:0]       result_ex_i,
  input  logic                          branch_decision_i,
  input  logic                          lsu_resp_valid_i,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  output id_pkg::alu_req_t              alu_req_o,
  output id_pkg::rf_wr_t                rf_wr_o,
  output id_pkg::lsu_req_t              lsu_req_o,
  output logic                          pc_set_o,
  output logic                          instr_done_o,
  output logic                          illegal_insn_o
);

  id_pkg::dec_ctrl_t             ctrl;
  logic [id_pkg::REG_ADDR_W-1:0] rs1, rd;
  logic [id_pkg::XLEN-1:0]       imm, operand_a, operand_b, operand_b_mac;
  logic                          first_cycle;
  id_pkg::alu_op_e               alu_op;

  assign alu_req_o = {alu_op, operand_a, operand_b_mac};

  id_decoder #(.MacEn(MacEn)) decoder_i (
    .instr_i      (instr_i),
    .instr_valid_i(instr_valid_i),
    .ctrl_o       (ctrl),
    .rs1_o        (rs1),
    .rs2_o        (rf_raddr_b_o),
    .rd_o         (rd),
    .imm_o        (imm)
  );

  id_operand_mux operand_mux_i (
    .ctrl_i       (ctrl),
    .first_cycle_i(first_cycle),
    .pc_i         (pc_i),
    .rdata_a_i    (rf_rdata_a_i),
    .rdata_b_i    (rf_rdata_b_i),
    .imm_i        (imm),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b)
  );

  id_mac_sequencer mac_sequencer_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mac_i        (ctrl.mac),
    .first_cycle_i(first_cycle),
    .alu_op_i     (ctrl.alu_op),
    .operand_b_i  (operand_b),
    .result_ex_i  (result_ex_i),
    .rs1_i        (rs1),
    .rd_i         (rd),
    .alu_op_o     (alu_op),
    .operand_b_o  (operand_b_mac),
    .raddr_a_o    (rf_raddr_a_o)
  );

  id_fsm fsm_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .ctrl_i           (ctrl),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .rd_i             (rd),
    .lsu_wdata_i      (rf_rdata_b_i),
    .result_ex_i      (result_ex_i),
    .first_cycle_o    (first_cycle),
    .pc_set_o         (pc_set_o),
    .instr_done_o     (instr_done_o),
    .illegal_insn_o   (illegal_insn_o),
    .rf_wr_o          (rf_wr_o),
    .lsu_req_o        (lsu_req_o)
  );

endmodule

// File: tb/tb_id_stage.sv
// Testbench for the instruction decode stage
// Replays golden vectors and checks ALU request, pc set, LSU request and write-back per cycle

`timescale 1ns/1ps

module tb_id_stage;

  localparam int NumFields = 22;
  localparam int MaxVecs   = 64;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          instr_valid_i;
  logic [id_pkg::XLEN-1:0]       instr_i, pc_i;
  logic [id_pkg::XLEN-1:0]       rf_rdata_a_i, rf_rdata_b_i, result_ex_i;
  logic                          branch_decision_i, lsu_resp_valid_i;
  logic [id_pkg::REG_ADDR_W-1:0] rf_raddr_a_o, rf_raddr_b_o;
  id_pkg::alu_req_t              alu_req_o;
  id_pkg::rf_wr_t                rf_wr_o;
  id_pkg::lsu_req_t              lsu_req_o;
  logic                          pc_set_o, instr_done_o, illegal_insn_o;

  // Vector table, one row per golden line
  logic [31:0] vecs [MaxVecs][NumFields];
  int          num_vecs;
  logic        loaded;

  id_stage #(.MacEn(1'b1)) dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .pc_i             (pc_i),
    .rf_rdata_a_i     (rf_rdata_a_i),
    .rf_rdata_b_i     (rf_rdata_b_i),
    .result_ex_i      (result_ex_i),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .rf_raddr_a_o     (rf_raddr_a_o),
    .rf_raddr_b_o     (rf_raddr_b_o),
    .alu_req_o        (alu_req_o),
    .rf_wr_o          (rf_wr_o),
    .lsu_req_o        (lsu_req_o),
    .pc_set_o         (pc_set_o),
    .instr_done_o     (instr_done_o),
    .illegal_insn_o   (illegal_insn_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [NumFields];
    fd       = $fopen("tb/id_stage_golden.txt", "r");
    num_vecs = 0;
    assert (fd != 0) else begin
      $display("Cannot open the golden vector file");
      $display(">>> FAIL");
      $fatal(1);
    end
    while ($fgets(line, fd) > 0) begin
      // Skip comments and blank lines
      if (line.len() == 0 || line.getc(0) == 8'h23) begin
        continue;
      end
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                    f[21]);
      if (cnt <= 0) begin
        continue;
      end
      assert (cnt == NumFields && num_vecs < MaxVecs) else begin
        $display("Malformed or excess line in the golden vector file");
        $display(">>> FAIL");
        $fatal(1);
      end
      vecs[num_vecs] = f;
      num_vecs++;
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int idx);
    logic [31:0] v [NumFields];
    int          n;
    int          delay;
    int          exp_cycles;
    logic        is_lsu;
    logic        done;
    v      = vecs[idx];
    delay  = (v[7] == 0) ? 1 + int'($urandom % 4) : int'(v[7]);
    exp_cycles = (v[16] == 0) ? 1 + delay : int'(v[16]);
    // Memory ops by major opcode, unless decoded illegal
    is_lsu = ((v[0][6:0] == 7'h03) || (v[0][6:0] == 7'h23)) && (v[18] == 0);
    n      = 1;
    @(posedge clk_i);
    instr_valid_i     <= 1'b1;
    instr_i           <= v[0];
    pc_i              <= v[1];
    rf_rdata_a_i      <= v[2];
    rf_rdata_b_i      <= v[3];
    result_ex_i       <= v[4];
    branch_decision_i <= v[6][0];
    lsu_resp_valid_i  <= 1'b0;
    forever begin
      @(negedge clk_i);
      done = (n == exp_cycles);
      check_value("alu_req_o.op", (n == 1) ? v[8] : v[12], 32'(alu_req_o.op));
      check_value("alu_req_o.operand_a", (n == 1) ? v[9] : v[13], alu_req_o.operand_a);
      check_value("alu_req_o.operand_b", (n == 1) ? v[10] : v[14], alu_req_o.operand_b);
      check_value("rf_raddr_a_o", (n == 1) ? v[11] : v[15], 32'(rf_raddr_a_o));
      // Port B always reads the rs2 field
      check_value("rf_raddr_b_o", 32'(v[0][24:20]), 32'(rf_raddr_b_o));
      check_value("instr_done_o", 32'(done), 32'(instr_done_o));
      check_value("pc_set_o", 32'(n == int'(v[17])), 32'(pc_set_o));
      check_value("lsu_req_o.req", 32'(is_lsu && n == 1), 32'(lsu_req_o.req));
      if (is_lsu && n == 1) begin
        // Stores write, funct3 gives the size, LBU and LHU zero-extend
        check_value("lsu_req_o.we", 32'(v[0][6:0] == 7'h23), 32'(lsu_req_o.we));
        check_value("lsu_req_o.size", 32'(v[0][13:12]), 32'(lsu_req_o.size));
        check_value("lsu_req_o.sign_ext", 32'(v[0][6:0] == 7'h03 && v[0][14:12] < 3'd4),
                    32'(lsu_req_o.sign_ext));
        check_value("lsu_req_o.wdata", v[3], lsu_req_o.wdata);
      end
      check_value("illegal_insn_o", v[18], 32'(illegal_insn_o));
      check_value("rf_wr_o.we", 32'(done && v[19][0]), 32'(rf_wr_o.we));
      if (done && v[19][0]) begin
        check_value("rf_wr_o.waddr", v[20], 32'(rf_wr_o.waddr));
        check_value("rf_wr_o.wdata", v[21], rf_wr_o.wdata);
      end
      if (done) begin
        break;
      end
      @(posedge clk_i);
      n++;
      result_ex_i      <= v[5];
      lsu_resp_valid_i <= (n == 1 + delay);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    result_ex_i       = '0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    loaded            = 1'b0;
    void'($urandom(55284));
    load_vectors();
    loaded = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // Idle outputs after reset
    check_value("pc_set_o", 32'd0, 32'(pc_set_o));
    check_value("instr_done_o", 32'd0, 32'(instr_done_o));
    check_value("lsu_req_o.req", 32'd0, 32'(lsu_req_o.req));
    check_value("rf_wr_o.we", 32'd0, 32'(rf_wr_o.we));
    for (int i = 0; i < num_vecs; i++) begin
      run_vector(i);
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    $display(">>> PASS");
    $finish;
  end

  // Watchdog, 10 cycles per vector plus reset and margin
  initial begin
    wait (loaded);
    #((num_vecs * 10 + 2 + 20) * 8);
    $display("Timeout, the run did not finish in time");
    $display(">>> FAIL");
    $fatal(1);
  end

endmodule

// File: tb/id_stage_golden.txt
# instr pc rdata_a rdata_b res1 res2 bdec delay op1 a1 b1 ra1 op2 a2 b2 ra2 cycles pcset ill we waddr wdata
# delay 0 is random 1..4; cycles 0 means 1+delay; op is the alu_op_e index in hex
# ALU register and immediate ops
002081b3 00000100 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 0b0b0b0b 1 0 a0a0a0a0 0b0b0b0b 1 1 0 0 1 3 12345678
407302b3 00000104 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 1 a0a0a0a0 0b0b0b0b 6 1 a0a0a0a0 0b0b0b0b 6 1 0 0 1 5 12345678
ffb08213 00000108 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 fffffffb 1 0 a0a0a0a0 fffffffb 1 1 0 0 1 4 12345678
40315493 0000010c a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 7 a0a0a0a0 00000403 2 7 a0a0a0a0 00000403 2 1 0 0 1 9 12345678
7ff1c513 00000110 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 2 a0a0a0a0 000007ff 3 2 a0a0a0a0 000007ff 3 1 0 0 1 a 12345678
abcde3b7 00000114 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 00000000 abcde000 1b 0 00000000 abcde000 1b 1 0 0 1 7 12345678
00208033 00000118 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 0b0b0b0b 1 0 a0a0a0a0 0b0b0b0b 1 1 0 0 0 0 0
00d635b3 0000011c a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 9 a0a0a0a0 0b0b0b0b c 9 a0a0a0a0 0b0b0b0b c 1 0 0 1 b 12345678
# Branches, taken forward, not taken, taken backward
00208863 00000120 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 1 0 a a0a0a0a0 0b0b0b0b 1 a 00000120 00000010 1 2 2 0 0 0 0
fe209ce3 00000124 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 b a0a0a0a0 0b0b0b0b 1 b a0a0a0a0 0b0b0b0b 1 1 0 0 0 0 0
fe20ece3 00000128 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 1 0 e a0a0a0a0 0b0b0b0b 1 e 00000128 fffffff8 1 2 2 0 0 0 0
# JAL with link, then to x0
020000ef 0000012c a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 0000012c 00000020 0 0 0000012c 00000004 0 2 1 0 1 1 9abcdef0
ffdff06f 00000130 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 00000130 fffffffc 1f 0 00000130 00000004 1f 2 1 0 0 0 0
# Loads and stores
00812283 00000134 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 3 0 a0a0a0a0 00000008 2 0 a0a0a0a0 00000008 2 4 0 0 1 5 9abcdef0
fff08303 00000138 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 ffffffff 1 0 a0a0a0a0 ffffffff 1 0 0 0 1 6 9abcdef0
0020a623 0000013c a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 1 0 a0a0a0a0 0000000c 1 0 a0a0a0a0 0000000c 1 2 0 0 0 0 0
fe320f23 00000140 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 fffffffe 4 0 a0a0a0a0 fffffffe 4 0 0 0 0 0 0
# MAC on custom-0
0020840b 00000144 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 10 a0a0a0a0 0b0b0b0b 1 0 a0a0a0a0 12345678 8 2 0 0 1 8 9abcdef0
# Illegal encodings
022081b3 00000148 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 0b0b0b0b 1 0 a0a0a0a0 0b0b0b0b 1 1 0 1 0 0 0
00000000 0000014c a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 0b0b0b0b 0 0 a0a0a0a0 0b0b0b0b 0 1 0 1 0 0 0
00813283 00000150 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 0b0b0b0b 2 0 a0a0a0a0 0b0b0b0b 2 1 0 1 0 0 0
0220840b 00000154 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 0 a0a0a0a0 0b0b0b0b 1 0 a0a0a0a0 0b0b0b0b 1 1 0 1 0 0 0
# Back to a plain ALU op
0107e733 00000158 a0a0a0a0 0b0b0b0b 12345678 9abcdef0 0 0 3 a0a0a0a0 0b0b0b0b f 3 a0a0a0a0 0b0b0b0b f 1 0 0 1 e 12345678

// File: all.f
source/id_pkg.sv
source/id_decoder.sv
source/id_operand_mux.sv
source/id_mac_sequencer.sv
source/id_fsm.sv
source/id_stage.sv
tb/tb_id_stage.sv

// File: Makefile
SRCS := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_id_stage
	@out=$$(./obj_dir/Vtb_id_stage 2>&1); echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

obj_dir/Vtb_id_stage: $(SRCS) all.f
	verilator --binary --timing --assert -j 0 --top-module tb_id_stage -f all.f \
		-Mdir obj_dir -o Vtb_id_stage

clean:
	rm -rf obj_dir
